/* hdl/isp_pkg.sv */
`default_nettype none

package isp_pkg;

    // ======================================================================
    // data widths
    // ======================================================================
    typedef logic [7:0]   pixel_t;
    typedef logic [127:0] beat_t;
    typedef logic [31:0]  axi_addr_t;
    typedef logic [3:0]   pic_no_t;
    typedef logic [1:0]   ratio_t;
    typedef logic [1:0]   chan_t;
    typedef logic [23:0]  bright_sum_t;

    // ratio modes
    localparam ratio_t RATIO_QUARTER = 2'd0;
    localparam ratio_t RATIO_HALF    = 2'd1;
    localparam ratio_t RATIO_UNITY   = 2'd2;
    localparam ratio_t RATIO_DOUBLE  = 2'd3;

    // colour channel order in the burst
    localparam chan_t CHAN_RED   = 2'd0;
    localparam chan_t CHAN_GREEN = 2'd1;
    localparam chan_t CHAN_BLUE  = 2'd2;

    // ======================================================================
    // AXI and picture layout
    // ======================================================================
    localparam axi_addr_t  PIC_BASE       = 32'h0001_0000;
    localparam int         BYTES_PER_BEAT = 16;
    localparam logic [2:0] AXI_SIZE_16B   = 3'b100;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // sum of weighted bytes over a picture, divided down to an 8-bit mean
    localparam int BRIGHT_SHIFT = 10;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RUN,
        OUT_ZERO,
        OUT_BRIGHT
    } isp_state_t;

endpackage

`default_nettype wire

/* hdl/isp_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module isp_ctrl
    import isp_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  wire     in_valid,
    input  wire     [3:0] in_pic_no,
    input  wire     [1:0] in_ratio_mode,
    input  wire     done,
    input  wire     [7:0] brightness,
    input  wire     pic_is_zero,
    output logic    start,
    output pic_no_t pic_no,
    output ratio_t  ratio,
    output logic    clear,
    output logic    out_valid,
    output pixel_t  out_data
);

    localparam int NUM_PICS = 2 ** $bits(pic_no_t);

    isp_state_t          state;
    isp_state_t          state_nxt;
    logic [NUM_PICS-1:0] zero_tbl;
    logic                hit_zero;

    // known black picture, answered without DRAM traffic
    assign hit_zero = zero_tbl[pic_no];

    assign start = (state == LOOKUP) && !hit_zero;
    assign clear = start;

    // ======================================================================
    // request FSM
    // ======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                state_nxt = hit_zero ? OUT_ZERO : RUN;
            end
            RUN: begin
                if (done) begin
                    state_nxt = OUT_BRIGHT;
                end
            end
            OUT_ZERO:   state_nxt = IDLE;
            OUT_BRIGHT: state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request fields, held for the whole job
    always_ff @(posedge clk) begin
        if ((state == IDLE) && in_valid) begin
            pic_no <= in_pic_no;
            ratio  <= in_ratio_mode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zero_tbl <= '0;
        end else if (done && pic_is_zero) begin
            zero_tbl[pic_no] <= 1'b1;
        end
    end

    // result registered one cycle after the output state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= (state == OUT_ZERO) || (state == OUT_BRIGHT);
            out_data  <= (state == OUT_BRIGHT) ? brightness : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/dram_axi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_axi_master
    import isp_pkg::*;
#(
    parameter int CHANNEL_BEATS = 64
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire   [3:0] pic_no,

    output logic  [3:0] awid,
    output axi_addr_t   awaddr,
    output logic  [7:0] awlen,
    output logic  [2:0] awsize,
    output logic  [1:0] awburst,
    output logic        awvalid,
    input  wire         awready,
    output beat_t       wdata,
    output logic        wlast,
    output logic        wvalid,
    input  wire         wready,
    input  wire   [1:0] bresp,
    input  wire         bvalid,
    output logic        bready,

    output logic  [3:0] arid,
    output axi_addr_t   araddr,
    output logic  [7:0] arlen,
    output logic  [2:0] arsize,
    output logic  [1:0] arburst,
    output logic        arvalid,
    input  wire         arready,
    input  wire [127:0] rdata,
    input  wire         rvalid,
    output logic        rready,

    input  wire [127:0] exp_beat,
    input  wire         exp_strobe,
    output beat_t       rd_beat,
    output chan_t       rd_chan,
    output logic        rd_strobe,
    output logic        done
);

    localparam int        BURST_BEATS = 3 * CHANNEL_BEATS;
    localparam int        RD_CNT_W    = $clog2(CHANNEL_BEATS + 1);
    localparam int        WR_CNT_W    = $clog2(BURST_BEATS + 1);
    localparam axi_addr_t PIC_STRIDE  = axi_addr_t'(BURST_BEATS * BYTES_PER_BEAT);

    typedef logic [RD_CNT_W-1:0] rd_cnt_t;
    typedef logic [WR_CNT_W-1:0] wr_cnt_t;

    axi_addr_t pic_addr;
    logic      aw_done;
    logic      b_wait;
    rd_cnt_t   rd_cnt;
    wr_cnt_t   wr_cnt;

    // both bursts share id, length, size and address
    assign awid    = 4'd0;
    assign arid    = 4'd0;
    assign awlen   = 8'(BURST_BEATS - 1);
    assign arlen   = 8'(BURST_BEATS - 1);
    assign awsize  = AXI_SIZE_16B;
    assign arsize  = AXI_SIZE_16B;
    assign awburst = AXI_BURST_INCR;
    assign arburst = AXI_BURST_INCR;
    assign awaddr  = pic_addr;
    assign araddr  = pic_addr;
    assign bready  = 1'b1;

    // reads held off until the write burst is open
    assign rready    = aw_done;
    assign rd_strobe = rvalid && rready;
    assign rd_beat   = rdata;

    // ======================================================================
    // address channels
    // ======================================================================
    always_ff @(posedge clk) begin
        if (start) begin
            pic_addr <= PIC_BASE + axi_addr_t'(pic_no) * PIC_STRIDE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            aw_done <= 1'b0;
        end else if (start) begin
            arvalid <= 1'b1;
            awvalid <= 1'b1;
            aw_done <= 1'b0;
        end else begin
            if (arready) begin
                arvalid <= 1'b0;
            end
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                aw_done <= 1'b1;
            end else if (done) begin
                aw_done <= 1'b0;
            end
        end
    end

    // read beat count, channel steps every CHANNEL_BEATS beats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt  <= '0;
            rd_chan <= CHAN_RED;
        end else if (start) begin
            rd_cnt  <= '0;
            rd_chan <= CHAN_RED;
        end else if (rd_strobe) begin
            if (rd_cnt == rd_cnt_t'(CHANNEL_BEATS - 1)) begin
                rd_cnt  <= '0;
                rd_chan <= chan_t'(rd_chan + 1'b1);
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // ======================================================================
    // write data and response
    // ======================================================================
    always_ff @(posedge clk) begin
        if (exp_strobe) begin
            wdata <= exp_beat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
            wr_cnt <= '0;
        end else if (start) begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
            wr_cnt <= '0;
        end else begin
            wvalid <= exp_strobe;
            wlast  <= exp_strobe && (wr_cnt == wr_cnt_t'(BURST_BEATS - 1));
            if (exp_strobe) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_wait <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= b_wait && bvalid;
            if (wvalid && wready && wlast) begin
                b_wait <= 1'b1;
            end else if (bvalid) begin
                b_wait <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/exposure_scale.sv */
`timescale 1ns/1ps
`default_nettype none

module exposure_scale
    import isp_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire   [1:0] ratio,
    input  wire [127:0] rd_beat,
    input  wire   [1:0] rd_chan,
    input  wire         rd_strobe,
    output beat_t       exp_beat,
    output chan_t       exp_chan,
    output logic        exp_strobe
);

    beat_t scaled;

    // all 16 bytes in parallel
    always_comb begin
        pixel_t px;
        for (int i = 0; i < BYTES_PER_BEAT; i++) begin
            px = rd_beat[i*8 +: 8];
            case (ratio)
                RATIO_QUARTER: scaled[i*8 +: 8] = px >> 2;
                RATIO_HALF:    scaled[i*8 +: 8] = px >> 1;
                RATIO_UNITY:   scaled[i*8 +: 8] = px;
                // double, clipped at full scale
                default:       scaled[i*8 +: 8] = px[7] ? 8'hff : {px[6:0], 1'b0};
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_strobe <= 1'b0;
        end else begin
            exp_strobe <= rd_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            exp_beat <= scaled;
            exp_chan <= rd_chan;
        end
    end

endmodule

`default_nettype wire

/* hdl/brightness_acc.sv */
`timescale 1ns/1ps
`default_nettype none

module brightness_acc
    import isp_pkg::*;
#(
    parameter int CHANNEL_BEATS = 64
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         clear,
    input  wire [127:0] exp_beat,
    input  wire   [1:0] exp_chan,
    input  wire         exp_strobe,
    output pixel_t      brightness,
    output logic        pic_is_zero
);

    localparam int BURST_BEATS = 3 * CHANNEL_BEATS;
    localparam int CNT_W       = $clog2(BURST_BEATS + 1);
    localparam int HALF        = BYTES_PER_BEAT / 2;

    typedef logic [CNT_W-1:0] beat_cnt_t;
    typedef logic [10:0]      half_sum_t;

    beat_cnt_t   beat_cnt;
    logic        take;
    half_sum_t   half_lo_c;
    half_sum_t   half_hi_c;
    half_sum_t   half_lo;
    half_sum_t   half_hi;
    logic        half_valid;
    bright_sum_t acc;

    // beats past the end of a picture are not counted
    assign take = exp_strobe && (beat_cnt != beat_cnt_t'(BURST_BEATS));

    // green weighs 1/2, red and blue 1/4
    always_comb begin
        pixel_t w;
        half_lo_c = '0;
        half_hi_c = '0;
        for (int i = 0; i < BYTES_PER_BEAT; i++) begin
            w = (exp_chan == CHAN_GREEN) ? exp_beat[i*8 +: 8] >> 1 : exp_beat[i*8 +: 8] >> 2;
            if (i < HALF) begin
                half_lo_c = half_lo_c + half_sum_t'(w);
            end else begin
                half_hi_c = half_hi_c + half_sum_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            half_lo <= half_lo_c;
            half_hi <= half_hi_c;
        end
    end

    // ======================================================================
    // picture accumulator
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt    <= '0;
            half_valid  <= 1'b0;
            acc         <= '0;
            pic_is_zero <= 1'b1;
        end else if (clear) begin
            beat_cnt    <= '0;
            half_valid  <= 1'b0;
            acc         <= '0;
            pic_is_zero <= 1'b1;
        end else begin
            half_valid <= take;
            if (take) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (take && (|exp_beat)) begin
                pic_is_zero <= 1'b0;
            end
            if (half_valid) begin
                acc <= acc + bright_sum_t'(half_lo) + bright_sum_t'(half_hi);
            end
        end
    end

    assign brightness = pixel_t'(acc >> BRIGHT_SHIFT);

endmodule

`default_nettype wire

/* hdl/isp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module isp_top
    import isp_pkg::*;
#(
    parameter int CHANNEL_BEATS = 64
) (
    input  wire        clk,
    input  wire        rst_n,

    // request and result
    input  wire        in_valid,
    input  wire        [3:0] in_pic_no,
    input  wire        [1:0] in_ratio_mode,
    output logic       out_valid,
    output pixel_t     out_data,

    // AXI write address
    output logic [3:0] awid,
    output axi_addr_t  awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic       awvalid,
    input  wire        awready,

    // AXI write data and response
    output beat_t      wdata,
    output logic       wlast,
    output logic       wvalid,
    input  wire        wready,
    input  wire  [1:0] bresp,
    input  wire        bvalid,
    output logic       bready,

    // AXI read address and data
    output logic [3:0] arid,
    output axi_addr_t  araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    output logic       arvalid,
    input  wire        arready,
    input  wire [127:0] rdata,
    input  wire        rvalid,
    output logic       rready
);

    logic    start;
    pic_no_t pic_no;
    ratio_t  ratio;
    logic    clear;
    logic    done;
    pixel_t  brightness;
    logic    pic_is_zero;
    beat_t   rd_beat;
    chan_t   rd_chan;
    logic    rd_strobe;
    beat_t   exp_beat;
    chan_t   exp_chan;
    logic    exp_strobe;

    isp_ctrl isp_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pic_no     (in_pic_no),
        .in_ratio_mode (in_ratio_mode),
        .done          (done),
        .brightness    (brightness),
        .pic_is_zero   (pic_is_zero),
        .start         (start),
        .pic_no        (pic_no),
        .ratio         (ratio),
        .clear         (clear),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    dram_axi_master #(
        .CHANNEL_BEATS (CHANNEL_BEATS)
    ) dram_axi_master_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .pic_no     (pic_no),
        .awid       (awid),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .awburst    (awburst),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .exp_beat   (exp_beat),
        .exp_strobe (exp_strobe),
        .rd_beat    (rd_beat),
        .rd_chan    (rd_chan),
        .rd_strobe  (rd_strobe),
        .done       (done)
    );

    exposure_scale exposure_scale_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ratio      (ratio),
        .rd_beat    (rd_beat),
        .rd_chan    (rd_chan),
        .rd_strobe  (rd_strobe),
        .exp_beat   (exp_beat),
        .exp_chan   (exp_chan),
        .exp_strobe (exp_strobe)
    );

    brightness_acc #(
        .CHANNEL_BEATS (CHANNEL_BEATS)
    ) brightness_acc_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (clear),
        .exp_beat    (exp_beat),
        .exp_chan    (exp_chan),
        .exp_strobe  (exp_strobe),
        .brightness  (brightness),
        .pic_is_zero (pic_is_zero)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* tb/dram_axi_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_axi_model
    import isp_pkg::*;
#(
    parameter int CHANNEL_BEATS = 64,
    parameter int NUM_PICS      = 16
) (
    input  wire         clk,

    input  wire   [3:0] awid,
    input  wire  [31:0] awaddr,
    input  wire   [7:0] awlen,
    input  wire   [2:0] awsize,
    input  wire   [1:0] awburst,
    input  wire         awvalid,
    output logic        awready,
    input  wire [127:0] wdata,
    input  wire         wlast,
    input  wire         wvalid,
    output logic        wready,
    output logic  [1:0] bresp,
    output logic        bvalid,
    input  wire         bready,

    input  wire   [3:0] arid,
    input  wire  [31:0] araddr,
    input  wire   [7:0] arlen,
    input  wire   [2:0] arsize,
    input  wire   [1:0] arburst,
    input  wire         arvalid,
    output logic        arready,
    output beat_t       rdata,
    output logic        rvalid,
    input  wire         rready
);

    localparam int PIC_BEATS  = 3 * CHANNEL_BEATS;
    localparam int MEM_BEATS  = NUM_PICS * PIC_BEATS;
    localparam int PIC_STRIDE = PIC_BEATS * BYTES_PER_BEAT;

    // AXI encodings of a 16-byte beat and of an incrementing burst
    localparam logic [2:0] SIZE_16_BYTES = 3'd4;
    localparam logic [1:0] BURST_INCR    = 2'b01;

    beat_t     mem [MEM_BEATS];
    integer    seed = 66384;
    int        err_count = 0;
    int        ar_count = 0;
    axi_addr_t last_araddr = '0;
    axi_addr_t last_awaddr = '0;

    // checks one address request and returns the beat index of the picture
    function automatic int check_burst(input string kind, input logic [3:0] id,
                                       input axi_addr_t addr, input logic [7:0] len,
                                       input logic [2:0] size, input logic [1:0] burst);
        int offset;
        offset = int'(addr - PIC_BASE);
        if (id != 4'd0) begin
            $display("%s burst has id %0d instead of 0", kind, id);
            err_count++;
        end
        if (len != 8'(PIC_BEATS - 1)) begin
            $display("%s burst has length %0d instead of %0d", kind, len, PIC_BEATS - 1);
            err_count++;
        end
        if (size != SIZE_16_BYTES) begin
            $display("%s burst has size code %0d instead of 16 byte beats", kind, size);
            err_count++;
        end
        if (burst != BURST_INCR) begin
            $display("%s burst is not an incrementing burst (type %0d)", kind, burst);
            err_count++;
        end
        if (addr < PIC_BASE || offset % PIC_STRIDE != 0 || offset / PIC_STRIDE >= NUM_PICS) begin
            $display("%s burst address %h is not the start of a picture", kind, addr);
            err_count++;
            return 0;
        end
        return offset / BYTES_PER_BEAT;
    endfunction

    // ======================================================================
    // read side with random gaps in rvalid
    // ======================================================================
    initial begin
        int base;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        forever begin
            @(posedge clk);
            if (arvalid) begin
                last_araddr = araddr;
                base = check_burst("read", arid, araddr, arlen, arsize, arburst);
                #1 arready = 1'b1;
                @(posedge clk);
                ar_count++;
                #1 arready = 1'b0;
                for (int b = 0; b < PIC_BEATS; b++) begin
                    if (($random(seed) & 3) == 0) begin
                        rvalid = 1'b0;
                        @(posedge clk);
                        #1;
                    end
                    rdata  = mem[base + b];
                    rvalid = 1'b1;
                    @(posedge clk);
                    while (!rready) begin
                        @(posedge clk);
                    end
                    #1;
                end
                rvalid = 1'b0;
            end
        end
    end

    // ======================================================================
    // write side holds wready from AW until the last beat
    // ======================================================================
    initial begin
        int base;
        int beat;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = 2'b00;
        forever begin
            @(posedge clk);
            if (awvalid) begin
                last_awaddr = awaddr;
                base = check_burst("write", awid, awaddr, awlen, awsize, awburst);
                #1;
                awready = 1'b1;
                wready  = 1'b1;
                @(posedge clk);
                #1 awready = 1'b0;
                beat = 0;
                while (beat < PIC_BEATS) begin
                    @(posedge clk);
                    if (wvalid) begin
                        mem[base + beat] = wdata;
                        if (wlast != (beat == PIC_BEATS - 1)) begin
                            $display("write beat %0d carries wlast %0b", beat, wlast);
                            err_count++;
                        end
                        beat++;
                    end
                end
                #1;
                wready = 1'b0;
                bvalid = 1'b1;
                @(posedge clk);
                while (!bready) begin
                    @(posedge clk);
                end
                #1 bvalid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_isp.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_isp
    import isp_pkg::*;
();

    localparam int CHANNEL_BEATS = 64;
    localparam int PIC_BEATS     = 3 * CHANNEL_BEATS;
    localparam int NUM_PICS      = 16;
    localparam int PIC_STRIDE    = PIC_BEATS * BYTES_PER_BEAT;
    localparam int CLK_PERIOD    = 100;
    localparam int MAX_REQUESTS  = 12;
    localparam int REQ_CYCLES    = 400;
    localparam int ZERO_PIC      = 12;
    localparam int BRIGHT_PIC    = 7;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    pic_no_t    in_pic_no;
    ratio_t     in_ratio_mode;
    logic       out_valid;
    pixel_t     out_data;
    logic [3:0] awid;
    axi_addr_t  awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic       awvalid;
    logic       awready;
    beat_t      wdata;
    logic       wlast;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    logic [3:0] arid;
    axi_addr_t  araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       arvalid;
    logic       arready;
    beat_t      rdata;
    logic       rvalid;
    logic       rready;

    // shadow of DRAM as the reference sees it
    beat_t  shadow [NUM_PICS * PIC_BEATS];
    integer seed = 66384;
    int     errors = 0;
    int     checks = 0;
    int     requests = 0;
    int     test_no = 0;
    int     err_mark = 0;

    tb_clk_gen #(.PERIOD(CLK_PERIOD)) clk_gen_i (.clk(clk));

    dram_axi_model #(.CHANNEL_BEATS(CHANNEL_BEATS), .NUM_PICS(NUM_PICS)) dram_axi_model_i (
        .clk(clk),
        .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
        .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready)
    );

    isp_top isp_top_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_pic_no(in_pic_no), .in_ratio_mode(in_ratio_mode),
        .out_valid(out_valid), .out_data(out_data),
        .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
        .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready)
    );

    // ======================================================================
    // reference model
    // ======================================================================
    // scales one picture of the shadow in place, returns the mean brightness
    function automatic pixel_t ref_expose(input int pic, input ratio_t ratio);
        int base;
        int sum;
        int px;
        int scaled;
        base = pic * PIC_BEATS;
        sum  = 0;
        for (int b = 0; b < PIC_BEATS; b++) begin
            for (int i = 0; i < BYTES_PER_BEAT; i++) begin
                px = int'(shadow[base + b][i*8 +: 8]);
                case (ratio)
                    2'd0:    scaled = px / 4;
                    2'd1:    scaled = px / 2;
                    2'd2:    scaled = px;
                    default: scaled = (2 * px > 255) ? 255 : 2 * px;
                endcase
                shadow[base + b][i*8 +: 8] = 8'(scaled);
                // green is the middle third of the burst
                if (b / CHANNEL_BEATS == 1) begin
                    sum += scaled / 2;
                end else begin
                    sum += scaled / 4;
                end
            end
        end
        return pixel_t'(sum >> BRIGHT_SHIFT);
    endfunction

    function automatic int total_errors();
        return errors + dram_axi_model_i.err_count;
    endfunction

    task automatic check_value(input beat_t got, input beat_t expected, input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic finish_test(input string name);
        int now_errors;
        now_errors = total_errors();
        test_no++;
        $display("test %0d, %s: %0d errors", test_no, name, now_errors - err_mark);
        err_mark = now_errors;
    endtask

    // ======================================================================
    // stimulus helpers
    // ======================================================================
    task automatic load_beat(input int idx, input beat_t value);
        shadow[idx] = value;
        dram_axi_model_i.mem[idx] = value;
    endtask

    task automatic fill_memory();
        beat_t v;
        for (int a = 0; a < NUM_PICS * PIC_BEATS; a++) begin
            v = {$random(seed), $random(seed), $random(seed), $random(seed)};
            if (a / PIC_BEATS == ZERO_PIC) begin
                v = '0;
            end else if (a / PIC_BEATS == BRIGHT_PIC) begin
                v = v | {16{8'h60}};
            end
            load_beat(a, v);
        end
    endtask

    task automatic issue_request(input int pic, input ratio_t ratio);
        @(posedge clk);
        #1;
        in_valid      = 1'b1;
        in_pic_no     = pic_no_t'(pic);
        in_ratio_mode = ratio;
        @(posedge clk);
        #1 in_valid = 1'b0;
        requests++;
    endtask

    task automatic wait_result(output pixel_t data);
        int cycles;
        cycles = 0;
        data   = '0;
        @(negedge clk);
        while (!out_valid && cycles < REQ_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (out_valid) begin
            data = out_data;
        end else begin
            errors++;
            $display("no result came within %0d cycles of the request", REQ_CYCLES);
        end
    endtask

    task automatic run_request(input int pic, input ratio_t ratio, input string what);
        pixel_t    expected;
        pixel_t    got;
        axi_addr_t addr;
        expected = ref_expose(pic, ratio);
        addr     = PIC_BASE + axi_addr_t'(pic * PIC_STRIDE);
        issue_request(pic, ratio);
        wait_result(got);
        check_value(beat_t'(got), beat_t'(expected), {what, " brightness"});
        check_value(beat_t'(dram_axi_model_i.last_araddr), beat_t'(addr), {what, " read address"});
        check_value(beat_t'(dram_axi_model_i.last_awaddr), beat_t'(addr), {what, " write address"});
        for (int b = 0; b < PIC_BEATS; b++) begin
            check_value(dram_axi_model_i.mem[pic * PIC_BEATS + b], shadow[pic * PIC_BEATS + b],
                        {what, " write-back"});
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        int pic;
        int ar_before;
        in_valid      = 1'b0;
        in_pic_no     = '0;
        in_ratio_mode = '0;
        rst_n         = 1'b0;
        fill_memory();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        repeat (6) begin
            @(negedge clk);
            check_value(beat_t'(out_valid), '0, "out_valid after reset");
            check_value(beat_t'(arvalid), '0, "arvalid after reset");
            check_value(beat_t'(awvalid), '0, "awvalid after reset");
            check_value(beat_t'(wvalid), '0, "wvalid after reset");
        end
        check_value(beat_t'(dram_axi_model_i.ar_count), '0, "read bursts without a request");
        finish_test("idle after reset");

        pic = ($random(seed) & 32'h7fff_ffff) % 12;
        run_request(pic, 2'd2, "unity ratio");
        finish_test("unity ratio");

        run_request(4, 2'd0, "quarter ratio");
        run_request(4, 2'd1, "half ratio, second pass");
        run_request(9, 2'd1, "half ratio");
        finish_test("darkening ratios");

        run_request(BRIGHT_PIC, 2'd3, "double ratio");
        finish_test("double ratio with saturation");

        run_request(ZERO_PIC, 2'd2, "zero picture, first pass");
        ar_before = dram_axi_model_i.ar_count;
        issue_request(ZERO_PIC, 2'd1);
        // result is due on the second edge after the sampling edge
        for (int n = 0; n < 4; n++) begin
            @(negedge clk);
            check_value(beat_t'(out_valid), beat_t'(n == 2), "cached zero out_valid timing");
            check_value(beat_t'(arvalid), '0, "arvalid on cached zero picture");
            if (n == 2) begin
                check_value(beat_t'(out_data), '0, "cached zero out_data");
            end
        end
        check_value(beat_t'(dram_axi_model_i.ar_count), beat_t'(ar_before),
                    "read bursts on cached zero picture");
        finish_test("zero picture cache");

        $display("requests %0d, checks %0d, errors %0d", requests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(MAX_REQUESTS * REQ_CYCLES * CLK_PERIOD);
        $display("timeout, the run did not finish within %0d cycles",
                 MAX_REQUESTS * REQ_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/isp_pkg.sv
hdl/isp_ctrl.sv
hdl/dram_axi_master.sv
hdl/exposure_scale.sv
hdl/brightness_acc.sv
hdl/isp_top.sv
tb/tb_clk_gen.sv
tb/dram_axi_model.sv
tb/tb_isp.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run the testbench, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_isp -f filelist.f -o tb_isp \
    > build.log 2>&1 \
    && ./obj_dir/tb_isp > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log \
    && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
